//--- raster_trace.txt
# W addr data | S start | T stall_cycles | E x y rec_addr pix_addr | D wait for done
# All values are hex except the stall cycle count.
W 000 00001000
W 002 00080000
W 003 00000100
W 004 00400040
W 001 00000010
E 0000 0020 00001000 00082000
E 0010 0020 00001008 00082040
E 0020 0020 00001010 00082080
E 0030 0020 00001018 000820c0
E 0000 0030 00001020 00083000
E 0010 0030 00001028 00083040
E 0020 0030 00001030 00083080
E 0030 0030 00001038 000830c0
S
S
T 2
T 3
D
W 001 00000003
E 0000 0020 00001000 00082000
E 0010 0020 00001008 00082040
E 0020 0020 00001010 00082080
S
D
W 001 00000000
S
D

//--- vlog.f
raster_pkg.sv
raster_dcr.sv
raster_ctrl.sv
raster_tile_counter.sv
raster_addr_gen.sv
raster_top.sv
raster_clk_gen.sv
raster_assert.sv
raster_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module raster_tb -f vlog.f -o raster_sim

status=0
./obj_dir/raster_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    echo "Run failed"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "Run ended without a result"
    exit 1
fi

//--- raster_tb.sv
`timescale 1ns/1ps

module raster_tb;
    import raster_pkg::*;

    localparam int cycles_per_line  = 40;
    localparam int done_wait_cycles = 200;

    logic       clk;
    logic       rst_n;
    dcr_write_t dcr_write;
    logic       start;
    logic       stall;
    logic       tile_valid;
    tile_rec_t  tile;
    logic       busy;
    logic       done;

    tile_rec_t expected_q[$];
    int        mismatches    = 0;
    int        failures      = 0;
    int        trace_lines   = 0;
    bit        trace_counted = 1'b0;

    raster_clk_gen #(.period_ns(40), .reset_cycles(2)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    raster_top #(
        .num_instances (2),
        .instance_idx  (1)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .dcr_write  (dcr_write),
        .start      (start),
        .stall      (stall),
        .tile_valid (tile_valid),
        .tile       (tile),
        .busy       (busy),
        .done       (done)
    );

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got == want) else begin
            $display("Mismatch %s: got %h expected %h", name, got, want);
            mismatches++;
        end
    endtask

    task automatic check_field_count(input int got, input int want, input string line);
        assert (got == want) else begin
            $display("Malformed trace line, %0d of %0d fields read: %s", got, want, line);
            failures++;
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < done_wait_cycles);
        assert (done) else begin
            $display("done did not arrive within %0d cycles", done_wait_cycles);
            failures++;
        end
        assert (expected_q.size() == 0) else begin
            $display("done arrived with %0d expected records missing", expected_q.size());
            failures++;
        end
        if (done) begin
            @(negedge clk);
            assert (!busy) else begin
                $display("busy did not fall together with done");
                failures++;
            end
        end
    endtask

    // ------------------------------
    // Trace player
    // ------------------------------
    task automatic play_trace(input int fd);
        string       line;
        logic [31:0] a, b, c, d;
        int          n;
        int          code;
        while ($fgets(line, fd) != 0) begin
            case (line.getc(0))
                "W": begin
                    code = $sscanf(line, "W %h %h", a, b);
                    check_field_count(code, 2, line);
                    @(posedge clk);
                    dcr_write <= '{valid: 1'b1, addr: a[dcr_addr_bits-1:0], data: b};
                    @(posedge clk);
                    dcr_write.valid <= 1'b0;
                end
                "S": begin
                    @(posedge clk);
                    start <= 1'b1;
                    @(posedge clk);
                    start <= 1'b0;
                    @(negedge clk);
                    assert (busy) else begin
                        $display("busy did not rise after start");
                        failures++;
                    end
                end
                "T": begin
                    code = $sscanf(line, "T %d", n);
                    check_field_count(code, 1, line);
                    @(posedge clk);
                    stall <= 1'b1;
                    repeat (n) @(posedge clk);
                    stall <= 1'b0;
                end
                "E": begin
                    code = $sscanf(line, "E %h %h %h %h", a, b, c, d);
                    check_field_count(code, 4, line);
                    expected_q.push_back('{x: a[15:0], y: b[15:0], rec_addr: c, pix_addr: d});
                end
                "D": wait_for_done();
                "#", "\n": ; // Comment or blank line.
                default: begin
                    $display("Unknown trace command in line: %s", line);
                    failures++;
                end
            endcase
        end
    endtask

    // Records are checked at the falling edge, where the outputs have settled.
    always @(negedge clk) begin
        tile_rec_t want;
        if (rst_n && tile_valid) begin
            assert (expected_q.size() != 0) else begin
                $display("Unexpected tile record at x %h y %h", tile.x, tile.y);
                failures++;
            end
            if (expected_q.size() != 0) begin
                want = expected_q.pop_front();
                compare_field("tile.x", 32'(tile.x), 32'(want.x));
                compare_field("tile.y", 32'(tile.y), 32'(want.y));
                compare_field("tile.rec_addr", tile.rec_addr, want.rec_addr);
                compare_field("tile.pix_addr", tile.pix_addr, want.pix_addr);
            end
        end
    end

    initial begin
        wait (trace_counted);
        repeat (trace_lines * cycles_per_line) @(posedge clk);
        $display("Timeout after %0d cycles with the trace unfinished",
                 trace_lines * cycles_per_line);
        failures++;
        report_and_finish();
    end

    initial begin
        int    fd;
        string line;
        dcr_write = '0;
        start     = 1'b0;
        stall     = 1'b0;
        fd = $fopen("raster_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open raster_trace.txt");
            failures++;
        end else begin
            while ($fgets(line, fd) != 0) trace_lines++;
            $fclose(fd);
            trace_counted = 1'b1;
            fd = $fopen("raster_trace.txt", "r");
            wait (rst_n === 1'b1);
            @(negedge clk);
            assert (!tile_valid && !busy && !done) else begin
                $display("Outputs are not all low after reset");
                failures++;
            end
            play_trace(fd);
            $fclose(fd);
        end
        report_and_finish();
    end

endmodule

//--- raster_assert.sv
`timescale 1ns/1ps

module raster_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  stall,
    input logic                  tile_valid,
    input raster_pkg::tile_rec_t tile,
    input logic                  busy,
    input logic                  done
);
    // ------------------------------
    // Output protocol
    // ------------------------------
    // Done is one clean pulse, with no tile still leaving the pipeline.
    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !tile_valid && !$past(done))
        else $error("done was not a single pulse after the last tile");

    tile_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tile_valid |-> busy)
        else $error("tile_valid high while the rasterizer is not busy");

    // A stalled edge must leave the output record untouched.
    tile_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(tile))
        else $error("tile record changed across a stall");

endmodule

bind raster_top raster_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .tile_valid (tile_valid),
    .tile       (tile),
    .busy       (busy),
    .done       (done)
);

//--- raster_clk_gen.sv
`timescale 1ns/1ps

module raster_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1; // Released on an edge, like any other input.
    end

endmodule

//--- raster_top.sv
`timescale 1ns/1ps

module raster_top #(
    parameter int num_instances = 1,
    parameter int instance_idx  = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  raster_pkg::dcr_write_t dcr_write,
    input  logic                   start,
    input  logic                   stall,
    output logic                   tile_valid,
    output raster_pkg::tile_rec_t  tile,
    output logic                   busy,
    output logic                   done
);
    import raster_pkg::*;

    raster_dcrs_t dcrs;
    tile_pos_t    pos;
    logic         pos_valid;
    logic         last;
    logic         clear;
    logic         step;
    logic         pipe_empty;

    raster_dcr #(
        .num_instances (num_instances),
        .instance_idx  (instance_idx)
    ) u_dcr (
        .clk       (clk),
        .rst_n     (rst_n),
        .dcr_write (dcr_write),
        .dcrs      (dcrs)
    );

    raster_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .stall      (stall),
        .pos_valid  (pos_valid),
        .last       (last),
        .pipe_empty (pipe_empty),
        .clear      (clear),
        .step       (step),
        .busy       (busy),
        .done       (done)
    );

    raster_tile_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .dcrs      (dcrs),
        .clear     (clear),
        .step      (step),
        .stall     (stall),
        .pos       (pos),
        .pos_valid (pos_valid),
        .last      (last)
    );

    raster_addr_gen u_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .dcrs       (dcrs),
        .pos        (pos),
        .pos_valid  (pos_valid),
        .stall      (stall),
        .tile_valid (tile_valid),
        .tile       (tile),
        .pipe_empty (pipe_empty)
    );

endmodule

//--- raster_addr_gen.sv
`timescale 1ns/1ps

module raster_addr_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  raster_pkg::raster_dcrs_t dcrs,
    input  raster_pkg::tile_pos_t    pos,
    input  logic                     pos_valid,
    input  logic                     stall,
    output logic                     tile_valid,
    output raster_pkg::tile_rec_t    tile,
    output logic                     pipe_empty
);
    import raster_pkg::*;

    logic                     s1_valid;
    logic [dcr_data_bits-1:0] s1_rec_addr;
    logic [dcr_data_bits-1:0] s1_row_off;
    logic [dim_bits-1:0]      s1_x;
    logic [dim_bits-1:0]      s1_y;

    logic                     s2_valid;
    tile_rec_t                s2_tile;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= pos_valid;
            s2_valid <= s1_valid;
        end
    end

    // ------------------------------
    // Stage 1: slot address and row offset
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!stall && pos_valid) begin
            s1_rec_addr <= dcrs.tbuf_addr
                         + dcr_data_bits'(pos.index) * dcr_data_bits'(tile_rec_bytes);
            s1_row_off  <= dcr_data_bits'(pos.y) * dcr_data_bits'(dcrs.pbuf_stride);
            s1_x        <= pos.x;
            s1_y        <= pos.y;
        end
    end

    // ------------------------------
    // Stage 2: first pixel address
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!stall && s1_valid) begin
            s2_tile.x        <= s1_x;
            s2_tile.y        <= s1_y;
            s2_tile.rec_addr <= s1_rec_addr;
            s2_tile.pix_addr <= dcrs.pbuf_addr + s1_row_off
                              + dcr_data_bits'(s1_x) * dcr_data_bits'(pixel_bytes);
        end
    end

    assign tile_valid = s2_valid && !stall;
    assign tile       = s2_tile;

    // Stage two always empties on the next unstalled edge, so stage one decides.
    assign pipe_empty = !s1_valid;

endmodule

//--- raster_tile_counter.sv
`timescale 1ns/1ps

module raster_tile_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  raster_pkg::raster_dcrs_t dcrs,
    input  logic                     clear,
    input  logic                     step,
    input  logic                     stall,
    output raster_pkg::tile_pos_t    pos,
    output logic                     pos_valid,
    output logic                     last
);
    import raster_pkg::*;

    // One extra bit on the sums so that the compares see no wrap-around.
    logic [dim_bits:0]  x_next;
    logic [dim_bits:0]  y_next;
    logic [tile_bits:0] index_next;
    logic               wrap;
    logic               last_row;
    logic               last_limit;
    logic               band_empty;

    assign x_next     = {1'b0, pos.x} + (dim_bits + 1)'(tile_size);
    assign y_next     = {1'b0, pos.y} + (dim_bits + 1)'(tile_size);
    assign index_next = {1'b0, pos.index} + 1'b1;

    assign wrap       = (x_next >= {1'b0, dcrs.dst_xmax});
    assign last_row   = wrap && (y_next >= {1'b0, dcrs.dst_ymax});
    assign last_limit = (index_next >= {1'b0, dcrs.tile_count});
    assign last       = pos_valid && (last_row || last_limit);

    assign band_empty = (dcrs.dst_ymin >= dcrs.dst_ymax)
                     || (dcrs.dst_xmax == '0)
                     || (dcrs.tile_count == '0);

    // ------------------------------
    // Row-major stepper
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos       <= '0;
            pos_valid <= 1'b0;
        end else if (clear) begin
            pos.index <= '0;
            pos.x     <= '0;
            pos.y     <= dcrs.dst_ymin;
            pos_valid <= !band_empty;
        end else if (step && !stall) begin
            if (last) begin
                pos_valid <= 1'b0; // Stepped past the final tile.
            end else begin
                pos.index <= index_next[tile_bits-1:0];
                if (wrap) begin
                    pos.x <= '0;
                    pos.y <= y_next[dim_bits-1:0];
                end else begin
                    pos.x <= x_next[dim_bits-1:0];
                end
            end
        end
    end

endmodule

//--- raster_ctrl.sv
`timescale 1ns/1ps

module raster_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic stall,
    input  logic pos_valid,
    input  logic last,
    input  logic pipe_empty,
    output logic clear,
    output logic step,
    output logic busy,
    output logic done
);
    import raster_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_idle;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb begin
        state_next = state;
        clear      = 1'b0;
        step       = 1'b0;

        case (state)
            ctrl_idle: begin
                // Clear goes out in the start cycle, so the counter is loaded on the same edge.
                if (start && !stall) begin
                    clear      = 1'b1;
                    state_next = ctrl_walk;
                end
            end
            ctrl_walk: begin
                if (!stall) begin
                    step = pos_valid;
                    if (!pos_valid || last) begin
                        state_next = ctrl_drain;
                    end
                end
            end
            ctrl_drain: begin
                if (!stall && pipe_empty) begin
                    state_next = ctrl_done;
                end
            end
            ctrl_done: begin
                state_next = ctrl_idle; // Done is one cycle, stall or not.
            end
            default: begin
                state_next = ctrl_idle;
            end
        endcase
    end

    assign busy = (state != ctrl_idle);
    assign done = (state == ctrl_done);

endmodule

//--- raster_dcr.sv
`timescale 1ns/1ps

module raster_dcr #(
    parameter int num_instances = 1,
    parameter int instance_idx  = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  raster_pkg::dcr_write_t   dcr_write,
    output raster_pkg::raster_dcrs_t dcrs
);
    import raster_pkg::*;

    localparam int inst_log2 = $clog2(num_instances);
    localparam bit last_inst = (instance_idx == num_instances - 1);

    logic [dim_bits-1:0] dst_width;
    logic [dim_bits-1:0] dst_height;
    logic [dim_bits-1:0] band_height;
    logic [dim_bits-1:0] band_ymin;
    logic [dim_bits-1:0] band_ymax;

    raster_dcrs_t regs;

    // ------------------------------
    // Band of rows for this instance
    // ------------------------------
    assign dst_width   = dcr_write.data[0 +: dim_bits];
    assign dst_height  = dcr_write.data[16 +: dim_bits];
    assign band_height = dst_height >> inst_log2;

    assign band_ymin = dim_bits'(instance_idx * band_height);

    // The last instance also takes the rows left over by the division.
    assign band_ymax = last_inst ? dst_height : dim_bits'((instance_idx + 1) * band_height);

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (dcr_write.valid) begin
            case (dcr_write.addr)
                dcr_tbuf_addr: begin
                    regs.tbuf_addr <= dcr_write.data;
                end
                dcr_tile_count: begin
                    regs.tile_count <= dcr_write.data[tile_bits-1:0];
                end
                dcr_pbuf_addr: begin
                    regs.pbuf_addr <= dcr_write.data;
                end
                dcr_pbuf_stride: begin
                    regs.pbuf_stride <= dcr_write.data[stride_bits-1:0];
                end
                dcr_dst_size: begin
                    regs.dst_xmax <= dst_width;
                    regs.dst_ymin <= band_ymin;
                    regs.dst_ymax <= band_ymax;
                end
                default: begin
                    regs <= regs; // Unknown addresses are dropped.
                end
            endcase
        end
    end

    assign dcrs = regs;

endmodule

//--- raster_pkg.sv
package raster_pkg;

    // ------------------------------
    // DCR bus
    // ------------------------------
    localparam int dcr_addr_bits = 12;
    localparam int dcr_data_bits = 32;

    localparam logic [dcr_addr_bits-1:0] dcr_tbuf_addr   = 12'h000;
    localparam logic [dcr_addr_bits-1:0] dcr_tile_count  = 12'h001;
    localparam logic [dcr_addr_bits-1:0] dcr_pbuf_addr   = 12'h002;
    localparam logic [dcr_addr_bits-1:0] dcr_pbuf_stride = 12'h003;
    localparam logic [dcr_addr_bits-1:0] dcr_dst_size    = 12'h004; // Width low, height high.

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int dim_bits    = 16;
    localparam int tile_bits   = 16;
    localparam int stride_bits = 16;
    localparam int tile_log2   = 4;
    localparam int tile_size   = 1 << tile_log2;

    localparam int tile_rec_bytes = 8; // One slot in the tile-record buffer.
    localparam int pixel_bytes    = 4;

    // ------------------------------
    // Types
    // ------------------------------
    typedef struct packed {
        logic                     valid;
        logic [dcr_addr_bits-1:0] addr;
        logic [dcr_data_bits-1:0] data;
    } dcr_write_t;

    typedef struct packed {
        logic [dcr_data_bits-1:0] tbuf_addr;
        logic [tile_bits-1:0]     tile_count;
        logic [dcr_data_bits-1:0] pbuf_addr;
        logic [stride_bits-1:0]   pbuf_stride;
        logic [dim_bits-1:0]      dst_xmax;
        logic [dim_bits-1:0]      dst_ymin;   // First row of this instance's band.
        logic [dim_bits-1:0]      dst_ymax;   // One past the last row of the band.
    } raster_dcrs_t;

    typedef struct packed {
        logic [tile_bits-1:0] index;
        logic [dim_bits-1:0]  x;
        logic [dim_bits-1:0]  y;
    } tile_pos_t;

    typedef struct packed {
        logic [dim_bits-1:0]      x;
        logic [dim_bits-1:0]      y;
        logic [dcr_data_bits-1:0] rec_addr;
        logic [dcr_data_bits-1:0] pix_addr;
    } tile_rec_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_walk,
        ctrl_drain,
        ctrl_done
    } ctrl_state_e;

endpackage
